/* hdl/freq_meas_pkg.sv */
package freq_meas_pkg;

    // 32-bit hardware counters
    localparam int COUNT_W = 32;

    // Tick edges per gate, or gates since reset
    typedef logic [COUNT_W-1:0] freq_count_t;

    // Largest count before the counter would wrap
    localparam freq_count_t COUNT_MAX = {COUNT_W{1'b1}};

endpackage

/* hdl/wb_regs_pkg.sv */
package wb_regs_pkg;

    localparam int WB_ADR_W = 22;
    localparam int WB_DAT_W = 32;

    typedef logic [WB_ADR_W-1:0] wb_adr_t;
    typedef logic [WB_DAT_W-1:0] wb_dat_t;

    // Register map
    typedef enum wb_adr_t {
        ADDR_ADC_FREQ   = 22'h000000,
        ADDR_REF_FREQ   = 22'h000004,
        ADDR_GATE_COUNT = 22'h000008,
        ADDR_SOFT_RESET = 22'h008000   // Write only, bit 0
    } reg_addr_e;

    // Slave handshake states
    typedef enum logic {
        BUS_IDLE = 1'b0,
        BUS_ACK  = 1'b1
    } bus_state_e;

endpackage

/* hdl/gate_timer.sv */
`timescale 1ns/1ps

module gate_timer #(
    parameter int unsigned GATE_CYCLES = 100_000_000
) (
    input  logic ps_clk,
    input  logic reset_i,
    output logic gate_o
);

    localparam int CNT_W = (GATE_CYCLES > 1) ? $clog2(GATE_CYCLES) : 1;
    localparam logic [CNT_W-1:0] LAST_CNT = CNT_W'(GATE_CYCLES - 1);

    logic [CNT_W-1:0] cnt_q;

    // Free-running interval counter
    always_ff @(posedge ps_clk) begin
        if (reset_i) begin
            cnt_q <= '0;
        end else if (cnt_q == LAST_CNT) begin
            cnt_q <= '0;
        end else begin
            cnt_q <= cnt_q + 1'b1;
        end
    end

    // Pulse follows the zero count by one cycle
    always_ff @(posedge ps_clk) begin
        if (reset_i) begin
            gate_o <= 1'b0;
        end else begin
            gate_o <= (cnt_q == '0);
        end
    end

    // Gate must stay a single-cycle strobe for the counters downstream
    a_gate_single : assert property (
        @(posedge ps_clk) disable iff (reset_i)
        gate_o |=> !gate_o
    );

endmodule

/* hdl/edge_counter.sv */
`timescale 1ns/1ps

module edge_counter (
    input  logic                      ps_clk,
    input  logic                      reset_i,
    input  logic                      tick_i,
    input  logic                      gate_i,
    output freq_meas_pkg::freq_count_t freq_o
);

    import freq_meas_pkg::*;

    logic [1:0]  sync_q;     // Two-flop synchronizer
    logic        tick_d_q;   // Edge detect history
    logic        rise;
    freq_count_t count_q;

    always_ff @(posedge ps_clk) begin
        if (reset_i) begin
            sync_q   <= 2'b00;
            tick_d_q <= 1'b0;
        end else begin
            sync_q   <= {sync_q[0], tick_i};
            tick_d_q <= sync_q[1];
        end
    end

    assign rise = sync_q[1] & ~tick_d_q;

    // Count edges, restart at each gate
    always_ff @(posedge ps_clk) begin
        if (reset_i) begin
            count_q <= '0;
            freq_o  <= '0;
        end else if (gate_i) begin
            freq_o  <= count_q + freq_count_t'(rise);  // Edge seen in the gate cycle counts too
            count_q <= '0;
        end else begin
            count_q <= count_q + freq_count_t'(rise);
        end
    end

    // Gate interval too long for the counter width
    a_no_overflow : assert property (
        @(posedge ps_clk) disable iff (reset_i)
        (!gate_i && rise) |-> (count_q != COUNT_MAX)
    );

endmodule

/* hdl/wb_reg_bank.sv */
`timescale 1ns/1ps

module wb_reg_bank (
    input  logic                       ps_clk,
    input  logic                       reset_i,
    input  logic                       gate_i,
    input  freq_meas_pkg::freq_count_t adc_freq_i,
    input  freq_meas_pkg::freq_count_t ref_freq_i,
    input  logic                       wb_cyc_i,
    input  logic                       wb_stb_i,
    input  logic                       wb_we_i,
    input  wb_regs_pkg::wb_adr_t       wb_adr_i,
    input  wb_regs_pkg::wb_dat_t       wb_dat_i,
    output wb_regs_pkg::wb_dat_t       wb_dat_o,
    output logic                       wb_ack_o,
    output logic                       soft_reset_o
);

    import freq_meas_pkg::*;
    import wb_regs_pkg::*;

    bus_state_e  state_q;
    reg_addr_e   addr;
    logic        req;
    logic        reset_hit;
    freq_count_t gate_count_q;

    assign addr = reg_addr_e'(wb_adr_i);
    assign req  = wb_cyc_i & wb_stb_i & (state_q == BUS_IDLE);

    // Soft reset needs bit 0 set on the write
    assign reset_hit = req & wb_we_i & (addr == ADDR_SOFT_RESET) & wb_dat_i[0];

    // One ack cycle per request
    always_ff @(posedge ps_clk) begin
        if (reset_i) begin
            state_q <= BUS_IDLE;
        end else begin
            case (state_q)
                BUS_IDLE: if (req) state_q <= BUS_ACK;
                BUS_ACK:  state_q <= BUS_IDLE;
                default:  state_q <= BUS_IDLE;
            endcase
        end
    end

    assign wb_ack_o = (state_q == BUS_ACK);

    // Lines up with the ack of the write
    always_ff @(posedge ps_clk) begin
        if (reset_i) begin
            soft_reset_o <= 1'b0;
        end else begin
            soft_reset_o <= reset_hit;
        end
    end

    // Completed measurement intervals
    always_ff @(posedge ps_clk) begin
        if (reset_i || soft_reset_o) begin
            gate_count_q <= '0;
        end else if (gate_i) begin
            gate_count_q <= gate_count_q + 1'b1;
        end
    end

    // Address held stable by the master until ack
    always_comb begin
        case (addr)
            ADDR_ADC_FREQ:   wb_dat_o = adc_freq_i;
            ADDR_REF_FREQ:   wb_dat_o = ref_freq_i;
            ADDR_GATE_COUNT: wb_dat_o = gate_count_q;
            default:         wb_dat_o = '0;   // Soft reset and unmapped
        endcase
    end

    a_ack_single : assert property (
        @(posedge ps_clk) disable iff (reset_i)
        wb_ack_o |=> !wb_ack_o
    );

endmodule

/* hdl/clk_freq_monitor_top.sv */
`timescale 1ns/1ps

module clk_freq_monitor_top #(
    parameter int unsigned GATE_CYCLES = 100_000_000
) (
    input  logic                 ps_clk,
    input  logic                 reset_i,
    input  logic                 adc_tick_i,
    input  logic                 ref_tick_i,
    input  logic                 wb_cyc_i,
    input  logic                 wb_stb_i,
    input  logic                 wb_we_i,
    input  wb_regs_pkg::wb_adr_t wb_adr_i,
    input  wb_regs_pkg::wb_dat_t wb_dat_i,
    output wb_regs_pkg::wb_dat_t wb_dat_o,
    output logic                 wb_ack_o
);

    import freq_meas_pkg::*;

    logic        gate_pulse;
    logic        soft_reset;
    logic        meas_reset;
    freq_count_t adc_freq;
    freq_count_t ref_freq;

    // Bank stays on the board reset so it can finish the ack
    assign meas_reset = reset_i | soft_reset;

    gate_timer #(
        .GATE_CYCLES(GATE_CYCLES)
    ) u_gate (
        .ps_clk (ps_clk),
        .reset_i(meas_reset),
        .gate_o (gate_pulse)
    );

    edge_counter u_adc_count (
        .ps_clk (ps_clk),
        .reset_i(meas_reset),
        .tick_i (adc_tick_i),
        .gate_i (gate_pulse),
        .freq_o (adc_freq)
    );

    edge_counter u_ref_count (
        .ps_clk (ps_clk),
        .reset_i(meas_reset),
        .tick_i (ref_tick_i),
        .gate_i (gate_pulse),
        .freq_o (ref_freq)
    );

    wb_reg_bank u_regs (
        .ps_clk      (ps_clk),
        .reset_i     (reset_i),
        .gate_i      (gate_pulse),
        .adc_freq_i  (adc_freq),
        .ref_freq_i  (ref_freq),
        .wb_cyc_i    (wb_cyc_i),
        .wb_stb_i    (wb_stb_i),
        .wb_we_i     (wb_we_i),
        .wb_adr_i    (wb_adr_i),
        .wb_dat_i    (wb_dat_i),
        .wb_dat_o    (wb_dat_o),
        .wb_ack_o    (wb_ack_o),
        .soft_reset_o(soft_reset)
    );

endmodule

/* tb/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS    = 20,
    parameter int RESET_CYCLES = 10
) (
    output logic ps_clk_o,
    output logic reset_o
);

    initial begin
        ps_clk_o = 1'b0;
        forever #(PERIOD_NS / 2) ps_clk_o = ~ps_clk_o;
    end

    // Release on a falling edge, away from the DUT sampling edge
    initial begin
        reset_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge ps_clk_o);
        @(negedge ps_clk_o);
        reset_o = 1'b0;
    end

endmodule

/* tb/tb_checker.sv */
`timescale 1ns/1ps

module tb_checker (
    input  logic                 ps_clk,
    input  logic                 reset_i,
    input  logic                 wb_ack_i,
    input  wb_regs_pkg::wb_dat_t wb_dat_i,
    output int                   error_count_o
);

    import wb_regs_pkg::*;

    string   exp_name       = "";
    logic    exp_read       = 1'b0;
    wb_dat_t exp_lo         = '0;
    wb_dat_t exp_hi         = '0;
    int      req_seq        = 0;   // Requests announced by the master
    int      done_seq       = 0;   // Requests answered by an ack
    logic    ack_q          = 1'b0;
    int      check_count    = 0;
    int      mismatch_count = 0;
    int      protocol_count = 0;
    int      bus_fail_count = 0;

    assign error_count_o = mismatch_count + protocol_count + bus_fail_count;

    // Announced on the same falling edge that raises cyc
    task automatic expect_access(
        input string   name,
        input logic    is_read,
        input wb_dat_t lo,
        input wb_dat_t hi
    );
        exp_name = name;
        exp_read = is_read;
        exp_lo   = lo;
        exp_hi   = hi;
        req_seq++;
    endtask

    task automatic note_bus_failure(input string msg);
        bus_fail_count++;
        $display("%s", msg);
    endtask

    task automatic report_mismatch();
        if (exp_lo == exp_hi) begin
            $display("Mismatch in %s: expected %0d, actual %0d", exp_name, exp_lo, wb_dat_i);
        end else begin
            $display("Mismatch in %s: expected %0d to %0d, actual %0d",
                     exp_name, exp_lo, exp_hi, wb_dat_i);
        end
    endtask

    task automatic print_summary();
        $display("Read checks: %0d, mismatches: %0d, protocol errors: %0d, bus failures: %0d",
                 check_count, mismatch_count, protocol_count, bus_fail_count);
    endtask

    // Ack and read data are settled by the falling edge
    always @(negedge ps_clk) begin
        if (reset_i) begin
            ack_q = 1'b0;
        end else begin
            if (wb_ack_i && ack_q) begin
                protocol_count++;
                $display("Ack stayed high for a second cycle at %0t", $time);
            end else if (wb_ack_i) begin
                if (req_seq == done_seq) begin
                    protocol_count++;
                    $display("Ack arrived with no request pending at %0t", $time);
                end else begin
                    done_seq = req_seq;
                    if (exp_read) begin
                        check_count++;
                        if (wb_dat_i < exp_lo || wb_dat_i > exp_hi) begin
                            mismatch_count++;
                            report_mismatch();
                        end
                    end
                end
            end
            ack_q = wb_ack_i;
        end
    end

endmodule

/* tb/tb_top.sv */
`timescale 1ns/1ps

module tb_top;

    import wb_regs_pkg::*;
    import freq_meas_pkg::*;

    localparam int GATE_CYCLES    = 200;
    localparam int NUM_ROWS       = 5;
    localparam int ACK_LIMIT      = 10;
    localparam int TIMEOUT_CYCLES = NUM_ROWS * 4 * GATE_CYCLES + 500;

    logic    ps_clk;
    logic    reset;
    logic    adc_tick = 1'b0;
    logic    ref_tick = 1'b0;
    logic    wb_cyc   = 1'b0;
    logic    wb_stb   = 1'b0;
    logic    wb_we    = 1'b0;
    wb_adr_t wb_adr   = '0;
    wb_dat_t wb_dat_w = '0;
    wb_dat_t wb_dat_r;
    logic    wb_ack;
    int      error_count;

    int adc_half    = 2;   // Tick half-periods in ps_clk cycles
    int ref_half    = 2;
    int adc_phase   = 0;
    int ref_phase   = 0;
    int cycle_count = 0;

    // One row per test
    string   row_name    [NUM_ROWS];
    int      row_adc_per [NUM_ROWS];
    int      row_ref_per [NUM_ROWS];
    wb_dat_t row_adc_exp [NUM_ROWS];
    wb_dat_t row_ref_exp [NUM_ROWS];

    tb_clock_gen #(
        .PERIOD_NS   (20),
        .RESET_CYCLES(10)
    ) u_clk (
        .ps_clk_o(ps_clk),
        .reset_o (reset)
    );

    clk_freq_monitor_top #(
        .GATE_CYCLES(GATE_CYCLES)
    ) UUT (
        .ps_clk    (ps_clk),
        .reset_i   (reset),
        .adc_tick_i(adc_tick),
        .ref_tick_i(ref_tick),
        .wb_cyc_i  (wb_cyc),
        .wb_stb_i  (wb_stb),
        .wb_we_i   (wb_we),
        .wb_adr_i  (wb_adr),
        .wb_dat_i  (wb_dat_w),
        .wb_dat_o  (wb_dat_r),
        .wb_ack_o  (wb_ack)
    );

    tb_checker u_check (
        .ps_clk       (ps_clk),
        .reset_i      (reset),
        .wb_ack_i     (wb_ack),
        .wb_dat_i     (wb_dat_r),
        .error_count_o(error_count)
    );

    always @(negedge ps_clk) begin
        if (adc_phase >= adc_half - 1) begin
            adc_phase = 0;
            adc_tick  = ~adc_tick;
        end else begin
            adc_phase = adc_phase + 1;
        end
    end

    always @(negedge ps_clk) begin
        if (ref_phase >= ref_half - 1) begin
            ref_phase = 0;
            ref_tick  = ~ref_tick;
        end else begin
            ref_phase = ref_phase + 1;
        end
    end

    always @(posedge ps_clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Run stopped after %0d cycles without finishing the tests", cycle_count);
            u_check.print_summary();
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    task automatic set_row(input int idx, input string name, input int adc_per, input int ref_per);
        row_name[idx]    = name;
        row_adc_per[idx] = adc_per;
        row_ref_per[idx] = ref_per;
        row_adc_exp[idx] = wb_dat_t'(GATE_CYCLES / adc_per);   // Edges per gate
        row_ref_exp[idx] = wb_dat_t'(GATE_CYCLES / ref_per);
    endtask

    task automatic load_table();
        set_row(0, "period_4", 4, 4);
        set_row(1, "period_8", 8, 8);
        set_row(2, "period_10", 10, 10);
        set_row(3, "period_20", 20, 20);
        set_row(4, "unequal_8_20", 8, 20);
    endtask

    // Address and write data stay put after ack so read data holds for the checker
    task automatic bus_access(
        input  string   name,
        input  logic    we,
        input  wb_adr_t adr,
        input  wb_dat_t dat,
        input  wb_dat_t lo,
        input  wb_dat_t hi,
        output wb_dat_t rdata
    );
        int waited;
        @(negedge ps_clk);
        u_check.expect_access(name, !we, lo, hi);
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = dat;
        waited   = 0;
        do begin
            @(negedge ps_clk);
            waited++;
        end while (!wb_ack && waited < ACK_LIMIT);
        if (!wb_ack) begin
            u_check.note_bus_failure($sformatf("%s: no ack within %0d cycles", name, ACK_LIMIT));
        end
        rdata  = wb_dat_r;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic reg_read(
        input  string   name,
        input  wb_adr_t adr,
        input  wb_dat_t lo,
        input  wb_dat_t hi,
        output wb_dat_t rdata
    );
        bus_access(name, 1'b0, adr, '0, lo, hi, rdata);
    endtask

    task automatic reg_write(input string name, input wb_adr_t adr, input wb_dat_t dat);
        wb_dat_t unused;
        bus_access(name, 1'b1, adr, dat, '0, '0, unused);
    endtask

    initial begin
        wb_dat_t rdata;
        wb_dat_t gate_base;
        load_table();
        @(negedge reset);

        for (int i = 0; i < NUM_ROWS; i++) begin
            @(posedge ps_clk);
            adc_half = row_adc_per[i] / 2;
            ref_half = row_ref_per[i] / 2;
            repeat (3 * GATE_CYCLES) @(negedge ps_clk);   // At least one full gate at the new rate
            reg_read($sformatf("%s adc", row_name[i]), ADDR_ADC_FREQ,
                     row_adc_exp[i] - 1, row_adc_exp[i] + 1, rdata);
            reg_read($sformatf("%s ref", row_name[i]), ADDR_REF_FREQ,
                     row_ref_exp[i] - 1, row_ref_exp[i] + 1, rdata);
        end

        reg_read("gate_count_first", ADDR_GATE_COUNT, NUM_ROWS * 3, COUNT_MAX, gate_base);
        repeat (2 * GATE_CYCLES) @(negedge ps_clk);
        reg_read("gate_count_second", ADDR_GATE_COUNT, gate_base + 2, gate_base + 3, rdata);

        reg_read("unmapped_low", 22'h00000C, '0, '0, rdata);
        reg_read("unmapped_high", 22'h3FFFFC, '0, '0, rdata);
        reg_read("soft_reset_read", ADDR_SOFT_RESET, '0, '0, rdata);

        // Measurement side restarts, next latched value is still empty
        reg_write("soft_reset_set", ADDR_SOFT_RESET, 32'h1);
        reg_read("gate_count_after_reset", ADDR_GATE_COUNT, '0, '0, rdata);
        reg_read("adc_after_reset", ADDR_ADC_FREQ, '0, '0, rdata);
        reg_read("ref_after_reset", ADDR_REF_FREQ, '0, '0, rdata);

        repeat (GATE_CYCLES) @(negedge ps_clk);
        reg_write("soft_reset_clear", ADDR_SOFT_RESET, 32'h0);
        reg_read("gate_count_kept", ADDR_GATE_COUNT, 32'd1, COUNT_MAX, rdata);

        u_check.print_summary();
        if (error_count == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

/* filelist.f */
hdl/freq_meas_pkg.sv
hdl/wb_regs_pkg.sv
hdl/gate_timer.sv
hdl/edge_counter.sv
hdl/wb_reg_bank.sv
hdl/clk_freq_monitor_top.sv
tb/tb_clock_gen.sv
tb/tb_checker.sv
tb/tb_top.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_top
FILELIST  = filelist.f
OBJ_DIR   = obj_dir
LOG       = sim.log
FAIL_MSG  = TESTBENCH FAILED
PASS_MSG  = TESTBENCH PASSED

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed, see $(LOG)"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation ended early, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
